// ==== Bender.yml ====
package:
  name: gtx_tx_pcs

sources:
  - files:
      - src/gtx_tx_pkg.sv
      - src/tx_lane_if.sv
      - src/tx_word_splitter.sv
      - src/tx_8b10b_encoder.sv
      - src/gtx_tx_pcs.sv
  - target: test
    files:
      - test/tb_gtx_tx_pcs.sv

// ==== list.f ====
src/gtx_tx_pkg.sv
src/tx_lane_if.sv
src/tx_word_splitter.sv
src/tx_8b10b_encoder.sv
src/gtx_tx_pcs.sv
test/tb_gtx_tx_pcs.sv

// ==== src/gtx_tx_pcs.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * gtx tx pcs top level
 * word splitter feeding the 8b/10b encoder over one lane link,
 * driving the transceiver in 8b/10b bypass mode
 */
module gtx_tx_pcs
    import gtx_tx_pkg::*;
(
    input  wire                          txusrclk,
    input  wire                          rst_n,
    input  wire  [word_bytes*byte_w-1:0] txdata,
    input  wire  [word_bytes-1:0]        txcharisk,
    input  wire                          txelecidle,
    input  wire                          txcominit,
    input  wire                          txcomwake,
    input  wire                          txvalid,
    output logic                         txready,
    output logic [lane_bytes*byte_w-1:0] gtx_txdata,
    output logic [lane_bytes-1:0]        gtx_txchardispmode,
    output logic [lane_bytes-1:0]        gtx_txchardispval,
    output logic                         gtx_txelecidle,
    output logic                         gtx_txcominit,
    output logic                         gtx_txcomwake
);

    tx_lane_if lane ();

    tx_word_splitter u_splitter (
        .txusrclk   (txusrclk),
        .rst_n      (rst_n),
        .txdata     (txdata),
        .txcharisk  (txcharisk),
        .txelecidle (txelecidle),
        .txcominit  (txcominit),
        .txcomwake  (txcomwake),
        .txvalid    (txvalid),
        .txready    (txready),
        .lane       (lane.source)
    );

    tx_8b10b_encoder u_encoder (
        .txusrclk           (txusrclk),
        .rst_n              (rst_n),
        .lane               (lane.sink),
        .gtx_txdata         (gtx_txdata),
        .gtx_txchardispmode (gtx_txchardispmode),
        .gtx_txchardispval  (gtx_txchardispval),
        .gtx_txelecidle     (gtx_txelecidle),
        .gtx_txcominit      (gtx_txcominit),
        .gtx_txcomwake      (gtx_txcomwake)
    );

endmodule

`default_nettype wire

// ==== src/gtx_tx_pkg.sv ====
`default_nettype none
/*
 * gtx tx pcs shared definitions
 * byte and symbol widths, 8b/10b control characters, the idle lane
 * half and the 10-bit symbol type with its transceiver bypass view
 */
package gtx_tx_pkg;

    // user dword and lane half geometry
    localparam int word_bytes = 4;
    localparam int lane_bytes = 2;
    localparam int byte_w     = 8;
    localparam int symbol_w   = 10;

    // comma and filler characters
    localparam logic [byte_w-1:0] k28_5 = 8'hBC;
    localparam logic [byte_w-1:0] d10_2 = 8'h4A;

    // idle half, comma in byte 0 and filler in byte 1
    localparam logic [lane_bytes*byte_w-1:0] idle_data = {d10_2, k28_5};
    localparam logic [lane_bytes-1:0]        idle_isk  = 2'b01;

    // one code group, bit 0 leaves the serializer first
    // the bypass view is how the transceiver splits it on txdata,
    // txchardispmode and txchardispval
    typedef union packed {
        logic [symbol_w-1:0] raw;
        struct packed {
            logic              disp_mode;
            logic              disp_val;
            logic [byte_w-1:0] data;
        } bypass;
    } tx_symbol_t;

endpackage

`default_nettype wire

// ==== src/tx_8b10b_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * tx 8b/10b encoder
 * encodes both bytes of a lane half with one running disparity,
 * byte 0 first, and registers the code groups in the transceiver's
 * bypass format together with the out-of-band flags
 */
module tx_8b10b_encoder
    import gtx_tx_pkg::*;
(
    input  wire                         txusrclk,
    input  wire                         rst_n,
    tx_lane_if.sink                     lane,
    output logic [lane_bytes*byte_w-1:0] gtx_txdata,
    output logic [lane_bytes-1:0]        gtx_txchardispmode,
    output logic [lane_bytes-1:0]        gtx_txchardispval,
    output logic                         gtx_txelecidle,
    output logic                         gtx_txcominit,
    output logic                         gtx_txcomwake
);

    // 5b/6b codes for negative disparity, abcdei with a as msb
    function automatic logic [5:0] code6_neg(input logic [4:0] x);
        case (x)
            5'd0:    code6_neg = 6'b100111;
            5'd1:    code6_neg = 6'b011101;
            5'd2:    code6_neg = 6'b101101;
            5'd3:    code6_neg = 6'b110001;
            5'd4:    code6_neg = 6'b110101;
            5'd5:    code6_neg = 6'b101001;
            5'd6:    code6_neg = 6'b011001;
            5'd7:    code6_neg = 6'b111000;
            5'd8:    code6_neg = 6'b111001;
            5'd9:    code6_neg = 6'b100101;
            5'd10:   code6_neg = 6'b010101;
            5'd11:   code6_neg = 6'b110100;
            5'd12:   code6_neg = 6'b001101;
            5'd13:   code6_neg = 6'b101100;
            5'd14:   code6_neg = 6'b011100;
            5'd15:   code6_neg = 6'b010111;
            5'd16:   code6_neg = 6'b011011;
            5'd17:   code6_neg = 6'b100011;
            5'd18:   code6_neg = 6'b010011;
            5'd19:   code6_neg = 6'b110010;
            5'd20:   code6_neg = 6'b001011;
            5'd21:   code6_neg = 6'b101010;
            5'd22:   code6_neg = 6'b011010;
            5'd23:   code6_neg = 6'b111010;
            5'd24:   code6_neg = 6'b110011;
            5'd25:   code6_neg = 6'b100110;
            5'd26:   code6_neg = 6'b010110;
            5'd27:   code6_neg = 6'b110110;
            5'd28:   code6_neg = 6'b001110;
            5'd29:   code6_neg = 6'b101110;
            5'd30:   code6_neg = 6'b011110;
            default: code6_neg = 6'b101011;
        endcase
    endfunction

    function automatic logic is_valid_k(input logic [byte_w-1:0] d);
        is_valid_k = (d[4:0] == 5'd28) ||
                     (d[7:5] == 3'd7 && (d[4:0] == 5'd23 || d[4:0] == 5'd27 ||
                                         d[4:0] == 5'd29 || d[4:0] == 5'd30));
    endfunction

    // returns {running disparity out, code group in raw order}
    function automatic logic [symbol_w:0] encode_byte(
        input logic [byte_w-1:0] d,
        input logic              k,
        input logic              rd_in
    );
        logic [4:0]          x;
        logic [2:0]          y;
        logic [5:0]          c6;
        logic [3:0]          c4;
        logic                rd_mid;
        logic                rd_out;
        logic [symbol_w-1:0] code_n;
        logic [symbol_w-1:0] raw;
        x  = d[4:0];
        y  = d[7:5];
        c6 = (k && x == 5'd28) ? 6'b001111 : code6_neg(x);
        // D.7 is balanced but still flips with disparity
        if (rd_in && ($countones(c6) != 3 || x == 5'd7))
            c6 = ~c6;
        rd_mid = ($countones(c6) != 3) ? ~rd_in : rd_in;
        case (y)
            3'd0:    c4 = 4'b1011;
            3'd1:    c4 = k ? 4'b0110 : 4'b1001;
            3'd2:    c4 = k ? 4'b1010 : 4'b0101;
            3'd3:    c4 = 4'b1100;
            3'd4:    c4 = 4'b1101;
            3'd5:    c4 = k ? 4'b0101 : 4'b1010;
            3'd6:    c4 = k ? 4'b1001 : 4'b0110;
            default:
            begin
                // alternate form avoids a run of five equal bits
                if (k || (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                    (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)))
                    c4 = 4'b0111;
                else
                    c4 = 4'b1110;
            end
        endcase
        if (rd_mid && ($countones(c4) != 2 || y == 3'd3 || k))
            c4 = ~c4;
        rd_out = ($countones(c4) != 2) ? ~rd_mid : rd_mid;
        code_n = {c6, c4};
        for (int i = 0; i < symbol_w; i++)
            raw[i] = code_n[symbol_w-1-i];
        encode_byte = {rd_out, raw};
    endfunction

    logic                         rd_q;
    logic [lane_bytes:0]          rd_chain;
    tx_symbol_t [lane_bytes-1:0]  sym_d;
    tx_symbol_t [lane_bytes-1:0]  sym_q;

    // disparity chained byte 0 into byte 1
    always_comb
    begin
        rd_chain[0] = rd_q;
        for (int i = 0; i < lane_bytes; i++)
            {rd_chain[i+1], sym_d[i].raw} = encode_byte(lane.lane_data[i*byte_w +: byte_w],
                                                        lane.lane_isk[i], rd_chain[i]);
    end

    always_ff @(posedge txusrclk)
    begin
        sym_q <= sym_d;
    end

    always_ff @(posedge txusrclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_q           <= 1'b0;
            gtx_txelecidle <= 1'b1;
            gtx_txcominit  <= 1'b0;
            gtx_txcomwake  <= 1'b0;
        end
        else
        begin
            rd_q           <= rd_chain[lane_bytes];
            gtx_txelecidle <= lane.lane_elecidle;
            gtx_txcominit  <= lane.lane_cominit;
            gtx_txcomwake  <= lane.lane_comwake;
        end
    end

    for (genvar i = 0; i < lane_bytes; i++)
    begin : g_out
        assign gtx_txdata[i*byte_w +: byte_w] = sym_q[i].bypass.data;
        assign gtx_txchardispmode[i]          = sym_q[i].bypass.disp_mode;
        assign gtx_txchardispval[i]           = sym_q[i].bypass.disp_val;
    end

    code_weight: assert property (
        @(posedge txusrclk) disable iff (!rst_n)
        $countones(sym_q[0].raw) inside {[4:6]} && $countones(sym_q[1].raw) inside {[4:6]}
    )
    else $error("code group with bad weight");

    // the splitter must only forward legal control characters
    k_legal: assert property (
        @(posedge txusrclk) disable iff (!rst_n)
        (!lane.lane_isk[0] || is_valid_k(lane.lane_data[byte_w-1:0])) &&
        (!lane.lane_isk[1] || is_valid_k(lane.lane_data[2*byte_w-1:byte_w]))
    )
    else $error("K flag on a byte that is no valid K character");

endmodule

`default_nettype wire

// ==== src/tx_lane_if.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * tx lane link
 * one 16-bit lane half with its K flags and the out-of-band flags,
 * driven by the word splitter and sampled by the encoder every cycle
 */
interface tx_lane_if
    import gtx_tx_pkg::*;
();

    logic [lane_bytes*byte_w-1:0] lane_data;
    logic [lane_bytes-1:0]        lane_isk;
    logic                         lane_elecidle;
    logic                         lane_cominit;
    logic                         lane_comwake;

    modport source (
        output lane_data,
        output lane_isk,
        output lane_elecidle,
        output lane_cominit,
        output lane_comwake
    );

    modport sink (
        input lane_data,
        input lane_isk,
        input lane_elecidle,
        input lane_cominit,
        input lane_comwake
    );

endinterface

`default_nettype wire

// ==== src/tx_word_splitter.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * tx word splitter
 * takes user dwords on a valid/ready handshake and steps them onto
 * the lane as low half then high half, filling empty cycles with the
 * idle half; out-of-band flags follow the last accepted dword
 */
module tx_word_splitter
    import gtx_tx_pkg::*;
(
    input  wire                         txusrclk,
    input  wire                         rst_n,
    input  wire [word_bytes*byte_w-1:0] txdata,
    input  wire [word_bytes-1:0]        txcharisk,
    input  wire                         txelecidle,
    input  wire                         txcominit,
    input  wire                         txcomwake,
    input  wire                         txvalid,
    output logic                        txready,
    tx_lane_if.source                   lane
);

    logic                         ready_q;
    logic                         low_pend;
    logic                         high_pend;
    logic                         accept;
    logic [word_bytes*byte_w-1:0] word_data_q;
    logic [word_bytes-1:0]        word_isk_q;
    logic [2:0]                   word_flags_q;

    assign accept  = txvalid & ready_q;
    assign txready = ready_q;

    // accepted dword, kept until its high half has moved out
    always_ff @(posedge txusrclk)
    begin
        if (accept)
        begin
            word_data_q  <= txdata;
            word_isk_q   <= txcharisk;
            word_flags_q <= {txelecidle, txcominit, txcomwake};
        end
    end

    // low half goes out one edge after acceptance, high half one more
    // a new dword may land on the edge that sends the old high half
    always_ff @(posedge txusrclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ready_q            <= 1'b0;
            low_pend           <= 1'b0;
            high_pend          <= 1'b0;
            lane.lane_data     <= idle_data;
            lane.lane_isk      <= idle_isk;
            lane.lane_elecidle <= 1'b1;
            lane.lane_cominit  <= 1'b0;
            lane.lane_comwake  <= 1'b0;
        end
        else
        begin
            ready_q   <= ~accept;
            low_pend  <= accept;
            high_pend <= low_pend;
            if (low_pend)
            begin
                lane.lane_data <= word_data_q[lane_bytes*byte_w-1:0];
                lane.lane_isk  <= word_isk_q[lane_bytes-1:0];
                {lane.lane_elecidle, lane.lane_cominit, lane.lane_comwake} <= word_flags_q;
            end
            else if (high_pend)
            begin
                lane.lane_data <= word_data_q[word_bytes*byte_w-1:lane_bytes*byte_w];
                lane.lane_isk  <= word_isk_q[word_bytes-1:lane_bytes];
            end
            else
            begin
                // nothing queued, flags stay as they were
                lane.lane_data <= idle_data;
                lane.lane_isk  <= idle_isk;
            end
        end
    end

    // source must hold a stalled dword
    hold_stable: assert property (
        @(posedge txusrclk) disable iff (!rst_n)
        txvalid && !txready |=> txvalid && $stable(txdata)
    )
    else $error("txvalid or txdata changed while stalled");

endmodule

`default_nettype wire

// ==== test/tb_gtx_tx_pcs.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * gtx tx pcs testbench
 * random dwords with random valid gaps from an LCG, checked every cycle
 * against a reference half schedule and a reference 8b/10b encoder
 */
module tb_gtx_tx_pcs
    import gtx_tx_pkg::*;
();

    localparam int n_words     = 4000;
    localparam int stim_cycles = n_words * 4 + 40;
    localparam int tail_cycles = 6;

    // 6b sub-blocks at negative running disparity, abcdei with a as msb
    localparam logic [0:31][5:0] six_neg = {
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };

    // 4b sub-blocks when the disparity after the 6b part is negative
    localparam logic [0:7][3:0] four_data = {4'b1011, 4'b1001, 4'b0101, 4'b1100,
                                             4'b1101, 4'b1010, 4'b0110, 4'b1110};
    localparam logic [0:7][3:0] four_k    = {4'b1011, 4'b0110, 4'b1010, 4'b1100,
                                             4'b1101, 4'b0101, 4'b1001, 4'b0111};

    logic        txusrclk;
    logic        rst_n;
    logic [31:0] txdata;
    logic [3:0]  txcharisk;
    logic        txelecidle;
    logic        txcominit;
    logic        txcomwake;
    logic        txvalid;
    logic        txready;
    logic [15:0] gtx_txdata;
    logic [1:0]  gtx_txchardispmode;
    logic [1:0]  gtx_txchardispval;
    logic        gtx_txelecidle;
    logic        gtx_txcominit;
    logic        gtx_txcomwake;

    // reference model state
    logic [31:0] seed;
    logic        ready_exp;
    logic        accepted;
    logic        rd_m;
    logic [2:0]  flags_m;
    logic [3:0]  slot_valid;
    logic [15:0] slot_data [4];
    logic [1:0]  slot_isk [4];
    logic [2:0]  slot_flags [4];
    int          cyc;
    int          n_acc;

    gtx_tx_pcs DUT (.*);

    initial txusrclk = 1'b0;

    always #5 txusrclk = ~txusrclk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // K28.0 to K28.7, then K23.7 K27.7 K29.7 K30.7
    function automatic logic [7:0] k_char(input logic [7:0] idx);
        case (idx)
            8'd8:    k_char = 8'hF7;
            8'd9:    k_char = 8'hFB;
            8'd10:   k_char = 8'hFD;
            8'd11:   k_char = 8'hFE;
            default: k_char = {idx[2:0], 5'd28};
        endcase
    endfunction

    // returns {disparity after, code group with a in bit 0}
    function automatic logic [10:0] ref_encode(input logic [7:0] b, input logic is_k,
                                               input logic rd);
        logic [4:0] x;
        logic [2:0] y;
        logic [5:0] six;
        logic [3:0] four;
        logic [9:0] abc;
        logic [9:0] raw;
        logic       mid;
        logic       alt;
        x   = b[4:0];
        y   = b[7:5];
        six = (is_k && x == 5'd28) ? 6'b001111 : six_neg[x];
        mid = ($countones(six) == 3) ? rd : ~rd;
        if (rd && (mid != rd || x == 5'd7))
            six = ~six;
        if (is_k)
            four = four_k[y];
        else if (y == 3'd7)
        begin
            alt  = mid ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                       : (x == 5'd17 || x == 5'd18 || x == 5'd20);
            four = alt ? 4'b0111 : 4'b1110;
        end
        else
            four = four_data[y];
        // K codes invert whole, data only when unbalanced or D.x.3
        if (mid && (is_k || $countones(four) != 2 || y == 3'd3))
            four = ~four;
        abc = {six, four};
        for (int i = 0; i < 10; i++)
            raw[i] = abc[9 - i];
        return {(($countones(four) == 2) ? mid : ~mid), raw};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp)
        begin
            $display("error %s expected %h got %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // one output cycle, the edge just taken sampled the inputs driven before it
    task automatic model_cycle();
        logic [15:0] half;
        logic [1:0]  isk;
        logic [10:0] e0;
        logic [10:0] e1;
        tx_symbol_t  s0;
        tx_symbol_t  s1;
        int          k;
        accepted = txvalid && ready_exp;
        if (accepted)
        begin
            // low half two cycles out, high half three
            k             = (cyc + 2) % 4;
            slot_valid[k] = 1'b1;
            slot_data[k]  = txdata[15:0];
            slot_isk[k]   = txcharisk[1:0];
            slot_flags[k] = {txelecidle, txcominit, txcomwake};
            k             = (cyc + 3) % 4;
            slot_valid[k] = 1'b1;
            slot_data[k]  = txdata[31:16];
            slot_isk[k]   = txcharisk[3:2];
            slot_flags[k] = {txelecidle, txcominit, txcomwake};
            n_acc++;
        end
        ready_exp = !accepted;
        check_value("txready", ready_exp, txready);
        k = cyc % 4;
        if (slot_valid[k])
        begin
            half          = slot_data[k];
            isk           = slot_isk[k];
            flags_m       = slot_flags[k];
            slot_valid[k] = 1'b0;
        end
        else
        begin
            half = idle_data;
            isk  = idle_isk;
        end
        e0     = ref_encode(half[7:0], isk[0], rd_m);
        e1     = ref_encode(half[15:8], isk[1], e0[10]);
        rd_m   = e1[10];
        s0.raw = e0[9:0];
        s1.raw = e1[9:0];
        check_value("gtx_txdata", {s1.bypass.data, s0.bypass.data}, gtx_txdata);
        check_value("gtx_txchardispmode", {s1.bypass.disp_mode, s0.bypass.disp_mode},
                    gtx_txchardispmode);
        check_value("gtx_txchardispval", {s1.bypass.disp_val, s0.bypass.disp_val},
                    gtx_txchardispval);
        check_value("gtx_txelecidle", flags_m[2], gtx_txelecidle);
        check_value("gtx_txcominit", flags_m[1], gtx_txcominit);
        check_value("gtx_txcomwake", flags_m[0], gtx_txcomwake);
        cyc++;
    endtask

    // a stalled dword is held, otherwise a new one is drawn
    task automatic drive_inputs();
        logic [31:0] r;
        if (!(txvalid && !accepted))
        begin
            r       = next_rand();
            txvalid = (n_acc < n_words) && r[31];
            for (int b = 0; b < 4; b++)
            begin
                r                = next_rand();
                txcharisk[b]     = (r[31:30] == 2'b00);
                txdata[b*8 +: 8] = txcharisk[b] ? k_char(r[23:16] % 8'd12) : r[23:16];
            end
            r = next_rand();
            {txelecidle, txcominit, txcomwake} = r[31:29];
        end
    endtask

    initial
    begin
        int tail;
        seed       = 32'hcee9_4252;
        rst_n      = 1'b0;
        txvalid    = 1'b0;
        txdata     = '0;
        txcharisk  = '0;
        txelecidle = 1'b0;
        txcominit  = 1'b0;
        txcomwake  = 1'b0;
        ready_exp  = 1'b0;
        accepted   = 1'b0;
        rd_m       = 1'b0;
        flags_m    = 3'b100;
        slot_valid = '0;
        cyc        = 0;
        n_acc      = 0;
        tail       = 0;
        repeat (10) @(negedge txusrclk);
        check_value("txready", 1'b0, txready);
        rst_n = 1'b1;
        while (tail < tail_cycles)
        begin
            @(negedge txusrclk);
            model_cycle();
            drive_inputs();
            if (n_acc == n_words && !txvalid)
                tail++;
        end
        $display("TEST OK");
        $finish;
    end

    initial
    begin
        #(2 * stim_cycles * 10);
        $display("TEST FAILED");
        $fatal(1, "run timed out after %0d cycles", 2 * stim_cycles);
    end

endmodule

`default_nettype wire
